// File: design/laser_drop_defs.svh
`ifndef LASER_DROP_DEFS_SVH
`define LASER_DROP_DEFS_SVH

// Clock cycles per laser bit
`define LD_CLKS_PER_BIT 8

// Majority vote window within one bit time
`define LD_VOTE_FIRST 3
`define LD_VOTE_LAST 5

// Start bit, eight data bits and stop bit
`define LD_FRAME_BITS 10

// Pair queue size, depth must be 2 ** AW
`define LD_QUEUE_DEPTH 16
`define LD_QUEUE_AW 4

`endif

// File: design/laser_drop_pkg.sv
`include "laser_drop_defs.svh"

package laser_drop_pkg;

    typedef logic [7:0] byte_t;

    // Bytes received on both lanes during one frame time
    typedef struct packed {
        byte_t data1;
        byte_t data2;
    } lane_pair_t;

    typedef logic [3:0] sample_count_t;
    typedef logic [3:0] bit_index_t;
    typedef logic [`LD_QUEUE_AW-1:0] queue_addr_t;

    typedef enum logic {
        rx_idle,
        rx_frame
    } rx_state_t;

    typedef enum logic [1:0] {
        wr_idle,
        wr_lane1,
        wr_gap,
        wr_lane2
    } wr_state_t;

endpackage

// File: design/laser_receiver.sv
`timescale 1ns/100ps
`include "laser_drop_defs.svh"

module laser_receiver (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       laser1_rx,
    input  logic                       laser2_rx,
    output laser_drop_pkg::lane_pair_t pair,
    output logic                       pair_valid
);

    // Lane arrays are indexed 0 for laser 1 and 1 for laser 2
    logic [1:0] lane_meta;
    logic [1:0] lane_sync;

    laser_drop_pkg::rx_state_t     state;
    laser_drop_pkg::sample_count_t sample_count;
    laser_drop_pkg::bit_index_t    bit_index;

    logic [1:0][1:0]                vote_q;
    logic [1:0][`LD_FRAME_BITS-1:0] shift_q;
    logic [1:0][`LD_FRAME_BITS-1:0] shift_next;
    logic [1:0]                     bit_now;
    logic [1:0]                     start_bits;
    logic [1:0]                     stop_bits;

    logic in_window;
    logic bit_end;
    logic last_bit;
    logic frame_ok;

    // Two-flop synchronizer on both lanes
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lane_meta <= 2'b00;
            lane_sync <= 2'b00;
        end else begin
            lane_meta <= {laser2_rx, laser1_rx};
            lane_sync <= lane_meta;
        end
    end

    assign in_window = (sample_count >= laser_drop_pkg::sample_count_t'(`LD_VOTE_FIRST)) &&
                       (sample_count <= laser_drop_pkg::sample_count_t'(`LD_VOTE_LAST));
    assign bit_end   = sample_count == laser_drop_pkg::sample_count_t'(`LD_CLKS_PER_BIT - 1);
    assign last_bit  = bit_index == laser_drop_pkg::bit_index_t'(`LD_FRAME_BITS - 1);

    // Two or three high samples out of three make a one
    always_comb begin
        for (int lane = 0; lane < 2; lane++) begin
            bit_now[lane]    = vote_q[lane][1];
            shift_next[lane] = {bit_now[lane], shift_q[lane][`LD_FRAME_BITS-1:1]};
            start_bits[lane] = shift_next[lane][0];
            stop_bits[lane]  = shift_next[lane][`LD_FRAME_BITS-1];
        end
        frame_ok = (start_bits == 2'b11) && (stop_bits == 2'b00);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state        <= laser_drop_pkg::rx_idle;
            sample_count <= '0;
            bit_index    <= '0;
            vote_q       <= '0;
            pair_valid   <= 1'b0;
        end else begin
            pair_valid <= 1'b0;
            case (state)
                laser_drop_pkg::rx_idle: begin
                    sample_count <= '0;
                    bit_index    <= '0;
                    vote_q       <= '0;
                    if (lane_sync != 2'b00) begin
                        state <= laser_drop_pkg::rx_frame;
                    end
                end
                laser_drop_pkg::rx_frame: begin
                    if (bit_end) begin
                        sample_count <= '0;
                        vote_q       <= '0;
                        bit_index    <= bit_index + 1'b1;
                        if (last_bit) begin
                            state      <= laser_drop_pkg::rx_idle;
                            pair_valid <= frame_ok;
                        end else if (bit_index == '0 && bit_now == 2'b00) begin
                            // Both start bits lost the vote, so this was a glitch
                            state <= laser_drop_pkg::rx_idle;
                        end
                    end else begin
                        sample_count <= sample_count + 1'b1;
                        if (in_window) begin
                            for (int lane = 0; lane < 2; lane++) begin
                                vote_q[lane] <= vote_q[lane] + {1'b0, lane_sync[lane]};
                            end
                        end
                    end
                end
                default: state <= laser_drop_pkg::rx_idle;
            endcase
        end
    end

    // Frame bits shift in at the top, so the start bit ends up in bit 0
    always_ff @(posedge clock) begin
        if (state == laser_drop_pkg::rx_frame && bit_end) begin
            shift_q <= shift_next;
            if (last_bit) begin
                pair.data1 <= shift_next[0][`LD_FRAME_BITS-2:1];
                pair.data2 <= shift_next[1][`LD_FRAME_BITS-2:1];
            end
        end
    end

endmodule

// File: design/pair_queue.sv
`timescale 1ns/100ps
`include "laser_drop_defs.svh"

module pair_queue (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       push,
    input  laser_drop_pkg::lane_pair_t push_data,
    input  logic                       pop,
    output laser_drop_pkg::lane_pair_t head,
    output logic                       empty,
    output logic                       overflow
);

    laser_drop_pkg::lane_pair_t mem [`LD_QUEUE_DEPTH];

    laser_drop_pkg::queue_addr_t wr_ptr;
    laser_drop_pkg::queue_addr_t rd_ptr;
    logic [`LD_QUEUE_AW:0]       occupancy;

    logic full;
    logic do_push;
    logic do_pop;

    assign empty   = occupancy == '0;
    assign full    = occupancy == (`LD_QUEUE_AW + 1)'(`LD_QUEUE_DEPTH);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Read side is combinational, a pushed pair shows up on the next cycle
    assign head = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            overflow  <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                occupancy <= occupancy + 1'b1;
            end else if (do_pop && !do_push) begin
                occupancy <= occupancy - 1'b1;
            end
            // Lost pairs are remembered until reset
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

// File: design/host_writer.sv
`timescale 1ns/100ps

module host_writer (
    input  logic                       clock,
    input  logic                       reset,
    input  laser_drop_pkg::lane_pair_t head,
    input  logic                       empty,
    input  logic                       txe,
    output laser_drop_pkg::byte_t      adbus_out,
    output logic                       ftdi_wr,
    output logic                       pop
);

    laser_drop_pkg::wr_state_t state;
    laser_drop_pkg::wr_state_t state_next;

    // txe low means the host has room for a byte
    always_comb begin
        state_next = state;
        case (state)
            laser_drop_pkg::wr_idle: begin
                if (!empty && !txe) begin
                    state_next = laser_drop_pkg::wr_lane1;
                end
            end
            laser_drop_pkg::wr_lane1: state_next = laser_drop_pkg::wr_gap;
            laser_drop_pkg::wr_gap: begin
                if (!txe) begin
                    state_next = laser_drop_pkg::wr_lane2;
                end
            end
            laser_drop_pkg::wr_lane2: state_next = laser_drop_pkg::wr_idle;
            default: state_next = laser_drop_pkg::wr_idle;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= laser_drop_pkg::wr_idle;
        end else begin
            state <= state_next;
        end
    end

    // Byte is loaded one edge ahead so it is steady for the whole strobe
    always_ff @(posedge clock) begin
        if (state_next == laser_drop_pkg::wr_lane1) begin
            adbus_out <= head.data1;
        end else if (state_next == laser_drop_pkg::wr_lane2) begin
            adbus_out <= head.data2;
        end
    end

    assign ftdi_wr = !(state == laser_drop_pkg::wr_lane1 || state == laser_drop_pkg::wr_lane2);
    assign pop     = state == laser_drop_pkg::wr_lane2;

endmodule

// File: design/laser_drop_top.sv
`timescale 1ns/100ps

module laser_drop_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  laser1_rx,
    input  logic                  laser2_rx,
    input  logic                  txe,
    output laser_drop_pkg::byte_t adbus_out,
    output logic                  ftdi_wr,
    output logic                  overflow
);

    laser_drop_pkg::lane_pair_t rx_pair;
    laser_drop_pkg::lane_pair_t queue_head;
    logic                       rx_pair_valid;
    logic                       queue_empty;
    logic                       writer_pop;

    laser_receiver receiver0 (
        .clock      (clock),
        .reset      (reset),
        .laser1_rx  (laser1_rx),
        .laser2_rx  (laser2_rx),
        .pair       (rx_pair),
        .pair_valid (rx_pair_valid)
    );

    pair_queue queue0 (
        .clock     (clock),
        .reset     (reset),
        .push      (rx_pair_valid),
        .push_data (rx_pair),
        .pop       (writer_pop),
        .head      (queue_head),
        .empty     (queue_empty),
        .overflow  (overflow)
    );

    host_writer writer0 (
        .clock     (clock),
        .reset     (reset),
        .head      (queue_head),
        .empty     (queue_empty),
        .txe       (txe),
        .adbus_out (adbus_out),
        .ftdi_wr   (ftdi_wr),
        .pop       (writer_pop)
    );

endmodule

// File: test/laser_drop_assert.sv
`timescale 1ns/100ps

module laser_drop_assert (
    input logic clock,
    input logic reset,
    input logic ftdi_wr,
    input logic pop,
    input logic empty,
    input logic overflow
);

    int assert_failures = 0;

    // Each host write strobe is a single low cycle
    strobe_single: assert property (@(posedge clock) disable iff (reset) !ftdi_wr |=> ftdi_wr)
        else begin
            assert_failures++;
            $error("ftdi_wr was low on two consecutive cycles");
        end

    pop_needs_entry: assert property (@(posedge clock) disable iff (reset) pop |-> !empty)
        else begin
            assert_failures++;
            $error("pop raised while the pair queue was empty");
        end

    // Overflow only clears through reset
    overflow_sticky: assert property (@(posedge clock) disable iff (reset) overflow |=> overflow)
        else begin
            assert_failures++;
            $error("overflow fell without a reset");
        end

endmodule

bind laser_drop_top laser_drop_assert assert0 (
    .clock    (clock),
    .reset    (reset),
    .ftdi_wr  (ftdi_wr),
    .pop      (writer_pop),
    .empty    (queue_empty),
    .overflow (overflow)
);

// File: test/laser_drop_tb.sv
`timescale 1ns/100ps
`include "laser_drop_defs.svh"

module laser_drop_tb;

    typedef laser_drop_pkg::byte_t byte_list_t[$];

    // About 57 frames of 96 cycles plus drain waits, stall time and margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int DRAIN_LIMIT    = 400;
    localparam int IDLE_GAP       = 16;

    logic                  clock;
    logic                  reset;
    logic                  laser1_rx;
    logic                  laser2_rx;
    logic                  txe;
    laser_drop_pkg::byte_t adbus_out;
    logic                  ftdi_wr;
    logic                  overflow;

    laser_drop_pkg::byte_t expected_q[$];
    laser_drop_pkg::byte_t expected_byte;
    laser_drop_pkg::byte_t pair_data1;
    laser_drop_pkg::byte_t pair_data2;
    string                 test_name;
    integer                seed;
    int                    cycle_count;
    int                    write_count;
    int                    writes_before;
    int                    value_errors;
    int                    extra_errors;
    int                    missing_errors;
    int                    flag_errors;
    int                    total_errors;

    laser_drop_top dut0 (
        .clock     (clock),
        .reset     (reset),
        .laser1_rx (laser1_rx),
        .laser2_rx (laser2_rx),
        .txe       (txe),
        .adbus_out (adbus_out),
        .ftdi_wr   (ftdi_wr),
        .overflow  (overflow)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    // Host bytes for one frame time with lane 1 first and none for a bad frame
    function automatic byte_list_t expected_bytes(input laser_drop_pkg::byte_t data1,
                                                  input laser_drop_pkg::byte_t data2,
                                                  input bit well_formed);
        byte_list_t bytes;
        if (well_formed) begin
            bytes.push_back(data1);
            bytes.push_back(data2);
        end
        return bytes;
    endfunction

    task automatic add_expected(input laser_drop_pkg::byte_t data1,
                                input laser_drop_pkg::byte_t data2,
                                input bit well_formed);
        byte_list_t bytes;
        bytes = expected_bytes(data1, data2, well_formed);
        foreach (bytes[i]) begin
            expected_q.push_back(bytes[i]);
        end
    endtask

    // flip_lane 0 means no flip and any other lane gets one inverted input cycle
    task automatic send_frame(input laser_drop_pkg::byte_t data1,
                              input laser_drop_pkg::byte_t data2,
                              input bit stop1,
                              input bit stop2,
                              input int flip_lane,
                              input int flip_bit,
                              input int flip_cycle);
        logic [`LD_FRAME_BITS-1:0] bits1;
        logic [`LD_FRAME_BITS-1:0] bits2;
        logic                      flip_here;
        bits1 = {stop1, data1, 1'b1};
        bits2 = {stop2, data2, 1'b1};
        for (int b = 0; b < `LD_FRAME_BITS; b++) begin
            for (int c = 0; c < `LD_CLKS_PER_BIT; c++) begin
                flip_here = (flip_bit == b) && (flip_cycle == c);
                @(posedge clock);
                laser1_rx <= bits1[b] ^ (flip_here && flip_lane == 1);
                laser2_rx <= bits2[b] ^ (flip_here && flip_lane == 2);
            end
        end
        for (int c = 0; c < IDLE_GAP; c++) begin
            @(posedge clock);
            laser1_rx <= 1'b0;
            laser2_rx <= 1'b0;
        end
    endtask

    // Start bit that drops before the vote window and a short idle line after it
    task automatic send_start_glitch(input int high_cycles);
        for (int c = 0; c < `LD_CLKS_PER_BIT + IDLE_GAP; c++) begin
            @(posedge clock);
            laser1_rx <= (c < high_cycles);
            laser2_rx <= (c < high_cycles);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("test %s: %0d host bytes never arrived", test_name, expected_q.size());
            missing_errors += expected_q.size();
            expected_q.delete();
        end
        // Room for any stray write to show up
        repeat (20) @(negedge clock);
    endtask

    // Host side of the port takes one byte per low cycle of ftdi_wr
    always @(negedge clock) begin
        if (!reset && ftdi_wr === 1'b0) begin
            write_count++;
            if (expected_q.size() == 0) begin
                extra_errors++;
                $display("test %s: unexpected host byte %02h was written", test_name, adbus_out);
            end else begin
                expected_byte = expected_q.pop_front();
                if (adbus_out !== expected_byte) begin
                    value_errors++;
                    $display("error %s: expected %02h actual %02h",
                             test_name, expected_byte, adbus_out);
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        seed           = 61186;
        write_count    = 0;
        value_errors   = 0;
        extra_errors   = 0;
        missing_errors = 0;
        flag_errors    = 0;
        reset          = 1'b1;
        laser1_rx      = 1'b0;
        laser2_rx      = 1'b0;
        txe            = 1'b0;
        test_name      = "reset";
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        test_name = "idle_after_reset";
        repeat (50) begin
            @(negedge clock);
            if (ftdi_wr !== 1'b1) begin
                flag_errors++;
                $display("error %s: ftdi_wr expected 1 actual %b", test_name, ftdi_wr);
            end
            if (overflow !== 1'b0) begin
                flag_errors++;
                $display("error %s: overflow expected 0 actual %b", test_name, overflow);
            end
        end

        test_name     = "single_pair";
        writes_before = write_count;
        add_expected(8'hA5, 8'h3C, 1'b1);
        send_frame(8'hA5, 8'h3C, 1'b0, 1'b0, 0, 0, 0);
        wait_drain();
        if (write_count - writes_before != 2) begin
            flag_errors++;
            $display("error %s: host writes expected 2 actual %0d",
                     test_name, write_count - writes_before);
        end

        test_name = "random_stream";
        for (int i = 0; i < 30; i++) begin
            pair_data1 = 8'($random(seed));
            pair_data2 = 8'($random(seed));
            add_expected(pair_data1, pair_data2, 1'b1);
            send_frame(pair_data1, pair_data2, 1'b0, 1'b0, 0, 0, 0);
        end
        wait_drain();

        test_name = "single_flips";
        add_expected(8'h5A, 8'hC3, 1'b1);
        send_frame(8'h5A, 8'hC3, 1'b0, 1'b0, 1, 3, 5);
        add_expected(8'h0F, 8'hF0, 1'b1);
        send_frame(8'h0F, 8'hF0, 1'b0, 1'b0, 2, 6, 1);
        add_expected(8'h81, 8'h7E, 1'b1);
        send_frame(8'h81, 8'h7E, 1'b0, 1'b0, 1, 0, 2);
        wait_drain();

        test_name = "bad_frames";
        add_expected(8'h11, 8'h22, 1'b0);
        send_frame(8'h11, 8'h22, 1'b1, 1'b0, 0, 0, 0);
        add_expected(8'h33, 8'h44, 1'b1);
        send_frame(8'h33, 8'h44, 1'b0, 1'b0, 0, 0, 0);
        send_start_glitch(3);
        add_expected(8'h55, 8'h66, 1'b1);
        send_frame(8'h55, 8'h66, 1'b0, 1'b0, 0, 0, 0);
        wait_drain();

        test_name = "host_stall";
        if (overflow !== 1'b0) begin
            flag_errors++;
            $display("error %s: overflow expected 0 actual %b", test_name, overflow);
        end
        @(posedge clock);
        txe <= 1'b1;
        writes_before = write_count;
        for (int i = 0; i < 20; i++) begin
            pair_data1 = 8'($random(seed));
            pair_data2 = 8'($random(seed));
            if (i < `LD_QUEUE_DEPTH) begin
                add_expected(pair_data1, pair_data2, 1'b1);
            end
            send_frame(pair_data1, pair_data2, 1'b0, 1'b0, 0, 0, 0);
        end
        repeat (10) @(negedge clock);
        if (overflow !== 1'b1) begin
            flag_errors++;
            $display("error %s: overflow expected 1 actual %b", test_name, overflow);
        end
        if (write_count != writes_before) begin
            flag_errors++;
            $display("error %s: host writes while stalled expected 0 actual %0d",
                     test_name, write_count - writes_before);
        end
        @(posedge clock);
        txe <= 1'b0;
        wait_drain();
        if (overflow !== 1'b1) begin
            flag_errors++;
            $display("error %s: overflow expected 1 actual %b", test_name, overflow);
        end

        total_errors = value_errors + extra_errors + missing_errors + flag_errors +
                       dut0.assert0.assert_failures;
        $display("errors: value %0d, extra %0d, missing %0d, flag %0d, assertion %0d",
                 value_errors, extra_errors, missing_errors, flag_errors,
                 dut0.assert0.assert_failures);
        if (total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: laser_drop.f
+incdir+design
design/laser_drop_pkg.sv
design/laser_receiver.sv
design/pair_queue.sv
design/host_writer.sv
design/laser_drop_top.sv
test/laser_drop_assert.sv
test/laser_drop_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the laser_drop testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module laser_drop_tb -f laser_drop.f -o laser_drop_sim

output=$(./obj_dir/laser_drop_sim +verilator+error+limit+1000)
echo "$output"

echo "$output" | grep -qx "Everything OK"
